/* src.f */
common/dma_target_pkg.sv
rtl/dma_packet_buffer.sv
dma_engine/dma_read_fifo.sv
dma_engine/dma_request_ctrl.sv
rtl/dma_target.sv
verification/dma_target_props.sv
verification/dma_target_checker.sv
verification/tb_dma_target.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the DMA target testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -f src.f --top-module tb_dma_target -o sim_dma_target

# A crash or a stopped simulation also fails through pipefail
./obj_dir/sim_dma_target 2>&1 | tee sim.log

if grep -q "sim failed" sim.log; then
  echo "Simulation reported failure"
  exit 1
fi

echo "Simulation finished without failure"
exit 0

/* verification/tb_dma_target.sv */
// DMA target testbench: random L2R and R2L requests, memory model and output back-pressure
`timescale 1ns/1ps

module tb_dma_target;
  import dma_target_pkg::*;

  localparam int          NUM_TESTS       = 30;
  localparam int          CYCLES_PER_TEST = 400;
  localparam int          TIMEOUT_CYCLES  = NUM_TESTS * CYCLES_PER_TEST;
  localparam logic [31:0] SEED            = 32'h9bde5d35;
  localparam logic [4:0]  TILE_ID         = 5'd3;

  logic                  clk = 1'b0;
  logic                  rst;
  flit_t                 noc_in_flit;
  logic                  noc_in_valid;
  logic                  noc_in_ready;
  flit_t                 noc_out_flit;
  logic                  noc_out_valid;
  logic                  noc_out_ready;
  logic                  mem_en;
  logic                  mem_we;
  logic [ADDR_WIDTH-1:0] mem_addr;
  logic [DATA_WIDTH-1:0] mem_wdata;
  logic [DATA_WIDTH-1:0] mem_rdata;

  logic [DATA_WIDTH-1:0] mem_model [1024];
  logic [31:0]           rng;
  int                    cycles;
  // Completed requests and last bit of the latest response header
  int                    done_cnt;
  logic                  hdr_last;
  int                    err_cnt;
  int                    check_cnt;
  int                    pending;

  // 40 ns period
  always #20 clk = ~clk;

  dma_target #(
    .tile_id (TILE_ID)
  ) u_dma_target (
    .clk             (clk),
    .rst             (rst),
    .noc_in_flit_i   (noc_in_flit),
    .noc_in_valid_i  (noc_in_valid),
    .noc_in_ready_o  (noc_in_ready),
    .noc_out_flit_o  (noc_out_flit),
    .noc_out_valid_o (noc_out_valid),
    .noc_out_ready_i (noc_out_ready),
    .mem_en_o        (mem_en),
    .mem_we_o        (mem_we),
    .mem_addr_o      (mem_addr),
    .mem_wdata_o     (mem_wdata),
    .mem_rdata_i     (mem_rdata)
  );

  dma_target_checker #(
    .tile_id (TILE_ID)
  ) u_checker (
    .clk         (clk),
    .rst         (rst),
    .in_flit_i   (noc_in_flit),
    .in_valid_i  (noc_in_valid),
    .in_ready_i  (noc_in_ready),
    .out_flit_i  (noc_out_flit),
    .out_valid_i (noc_out_valid),
    .out_ready_i (noc_out_ready),
    .mem_en_i    (mem_en),
    .mem_we_i    (mem_we),
    .mem_addr_i  (mem_addr),
    .mem_wdata_i (mem_wdata),
    .err_cnt_o   (err_cnt),
    .check_cnt_o (check_cnt),
    .pending_o   (pending)
  );

  bind dma_target dma_target_props u_props (
    .clk         (clk),
    .rst         (rst),
    .out_flit_i  (noc_out_flit_o),
    .out_valid_i (noc_out_valid_o),
    .out_ready_i (noc_out_ready_i),
    .mem_en_i    (mem_en_o),
    .mem_we_i    (mem_we_o)
  );

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [31:0] next_rand();
    rng = xorshift32(rng);
    return rng;
  endfunction

  function automatic logic [DATA_WIDTH-1:0] fill_word(input int idx);
    return 32'h5a000000 ^ (32'(idx) * 32'h00010101) ^ 32'(idx);
  endfunction

  //////////////////////////////
  // Memory model
  //////////////////////////////

  // Read data one cycle after the strobe, 4 KiB window
  always @(posedge clk) begin
    int i;
    if (rst) begin
      for (i = 0; i < 1024; i++) begin
        mem_model[i] <= fill_word(i);
      end
      mem_rdata <= '0;
    end else if (mem_en) begin
      if (mem_we) begin
        mem_model[mem_addr[11:2]] <= mem_wdata;
      end else begin
        mem_rdata <= mem_model[mem_addr[11:2]];
      end
    end
  end

  // Request ends on SINGLE, or on LAST of the final response packet
  always @(posedge clk) begin
    if (rst) begin
      done_cnt <= 0;
      hdr_last <= 1'b0;
    end else if (noc_out_valid && noc_out_ready) begin
      if (noc_out_flit.ftype == HEADER) begin
        // Header bit 0 is the last flag
        hdr_last <= noc_out_flit.content[0];
      end
      if ((noc_out_flit.ftype == SINGLE) || ((noc_out_flit.ftype == LAST) && hdr_last)) begin
        done_cnt <= done_cnt + 1;
      end
    end
  end

  always @(posedge clk) begin
    if (rst) begin
      cycles <= 0;
    end else begin
      cycles <= cycles + 1;
      if (cycles >= TIMEOUT_CYCLES) begin
        $display("Timeout: requests still open after %0d cycles", TIMEOUT_CYCLES);
        $display("sim failed");
        $finish;
      end
    end
  end

  // One clock with a fresh random output ready, about 3 in 4 cycles high
  task automatic step();
    logic [31:0] r;
    @(posedge clk);
    r = next_rand();
    noc_out_ready <= (r[1:0] != 2'b00);
  endtask

  task automatic send_flit(input flit_t f);
    noc_in_flit  <= f;
    noc_in_valid <= 1'b1;
    step();
    while (!noc_in_ready) begin
      step();
    end
  endtask

  //////////////////////////////
  // Request sequence
  //////////////////////////////

  initial begin
    flit_t                 f;
    header_t               h;
    logic [31:0]           r;
    logic [31:0]           a;
    logic [ADDR_WIDTH-1:0] laddr;
    logic [ADDR_WIDTH-1:0] raddr;
    logic                  is_read;
    int                    n;
    int                    k;
    int                    t;
    int                    errs_seen;
    int                    unmatched;
    string                 kind;
    rng           = SEED;
    rst           <= 1'b1;
    noc_in_flit   <= '0;
    noc_in_valid  <= 1'b0;
    noc_out_ready <= 1'b0;
    errs_seen     = 0;
    unmatched     = 0;
    repeat (16) @(posedge clk);
    rst <= 1'b0;
    for (t = 0; t < NUM_TESTS; t++) begin
      @(posedge clk);
      r       = next_rand();
      a       = next_rand();
      is_read = r[0];
      n       = is_read ? 1 + int'(r[31:16] % 16'd40) : 1 + int'(r[31:16] % 16'd14);
      // Word-aligned addresses inside a 1 KiB window
      laddr = {22'h0, a[9:2], 2'b00};
      raddr = {22'h0, a[19:12], 2'b00};
      h           = '0;
      h.dest      = TILE_ID;
      h.pclass    = PACKET_CLASS_DMA;
      h.src       = r[8:4];
      h.packet_id = r[15:12];
      h.ptype     = is_read ? R2L_REQ : L2R_REQ;
      h.size      = SIZE_WIDTH'(n);
      f.ftype   = HEADER;
      f.content = h;
      send_flit(f);
      f.ftype   = PAYLOAD;
      f.content = laddr;
      send_flit(f);
      if (is_read) begin
        f.ftype   = LAST;
        f.content = raddr;
        send_flit(f);
      end else begin
        for (k = 0; k < n; k++) begin
          f.ftype   = (k == n - 1) ? LAST : PAYLOAD;
          f.content = next_rand();
          send_flit(f);
        end
      end
      noc_in_valid <= 1'b0;
      while (done_cnt == t) begin
        step();
      end
      // Counts settle away from the active edge
      @(negedge clk);
      kind = is_read ? "R2L" : "L2R";
      $display("Test %0d: %s of %0d words, %0d errors, %0d unmatched", t, kind, n,
               err_cnt - errs_seen, pending);
      errs_seen = err_cnt;
      unmatched = unmatched + pending;
    end
    $display("Done: %0d tests, %0d checks, %0d errors, %0d unmatched", NUM_TESTS, check_cnt,
             err_cnt, unmatched);
    if ((err_cnt == 0) && (unmatched == 0)) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

/* verification/dma_target_checker.sv */
// DMA target reference model that predicts memory writes and response flits and compares them
`timescale 1ns/1ps

module dma_target_checker #(
  parameter logic [dma_target_pkg::TILE_ID_WIDTH-1:0] tile_id = '0
) (
  input  logic                                  clk,
  input  logic                                  rst,
  // NoC input as seen at the DUT
  input  dma_target_pkg::flit_t                 in_flit_i,
  input  logic                                  in_valid_i,
  input  logic                                  in_ready_i,
  // NoC output
  input  dma_target_pkg::flit_t                 out_flit_i,
  input  logic                                  out_valid_i,
  input  logic                                  out_ready_i,
  // Local memory strobes
  input  logic                                  mem_en_i,
  input  logic                                  mem_we_i,
  input  logic [dma_target_pkg::ADDR_WIDTH-1:0] mem_addr_i,
  input  logic [dma_target_pkg::DATA_WIDTH-1:0] mem_wdata_i,
  output int                                    err_cnt_o,
  output int                                    check_cnt_o,
  output int                                    pending_o
);
  import dma_target_pkg::*;

  typedef struct packed {
    logic [ADDR_WIDTH-1:0] addr;
    logic [DATA_WIDTH-1:0] data;
  } mem_wr_t;

  // Word-indexed copy of the 4 KiB memory window
  logic [DATA_WIDTH-1:0] mem_copy [1024];
  mem_wr_t               exp_writes [$];
  flit_t                 exp_flits [$];

  // Request being parsed from the NoC input
  header_t               req_hdr;
  logic [ADDR_WIDTH-1:0] laddr;
  logic [ADDR_WIDTH-1:0] raddr;
  int                    in_idx;

  // Same power-on contents as the memory model
  function automatic logic [DATA_WIDTH-1:0] fill_word(input int idx);
    return 32'h5a000000 ^ (32'(idx) * 32'h00010101) ^ 32'(idx);
  endfunction

  function automatic header_t resp_header(input packet_type_e ptype);
    header_t h;
    h           = '0;
    h.dest      = req_hdr.src;
    h.pclass    = PACKET_CLASS_DMA;
    h.src       = tile_id;
    h.packet_id = req_hdr.packet_id;
    h.ptype     = ptype;
    return h;
  endfunction

  task automatic queue_l2r_resp();
    flit_t f;
    f.ftype   = SINGLE;
    f.content = resp_header(L2R_RESP);
    exp_flits.push_back(f);
  endtask

  // Split the read into packets of at most 14 words
  task automatic queue_r2l_resp();
    int                    total;
    int                    sent;
    int                    sz;
    int                    k;
    header_t               h;
    flit_t                 f;
    logic [ADDR_WIDTH-1:0] a;
    total = int'(req_hdr.size);
    sent  = 0;
    while (sent < total) begin
      sz = (total - sent < MAX_PAYLOAD_WORDS) ? total - sent : MAX_PAYLOAD_WORDS;
      h       = resp_header(R2L_RESP);
      h.size  = SIZE_WIDTH'(sz);
      h.last  = (sent + sz == total);
      f.ftype   = HEADER;
      f.content = h;
      exp_flits.push_back(f);
      // Remote address advances by the words already sent
      f.ftype   = PAYLOAD;
      f.content = raddr + ADDR_WIDTH'(4 * sent);
      exp_flits.push_back(f);
      for (k = 0; k < sz; k++) begin
        a         = laddr + ADDR_WIDTH'(4 * (sent + k));
        f.ftype   = (k == sz - 1) ? LAST : PAYLOAD;
        f.content = mem_copy[a[11:2]];
        exp_flits.push_back(f);
      end
      sent = sent + sz;
    end
  endtask

  //////////////////////////////
  // Monitor and compare
  //////////////////////////////

  always @(posedge clk) begin
    int                    i;
    flit_t                 f;
    mem_wr_t               w;
    logic [ADDR_WIDTH-1:0] a;
    if (rst) begin
      for (i = 0; i < 1024; i++) begin
        mem_copy[i] = fill_word(i);
      end
      exp_writes.delete();
      exp_flits.delete();
      in_idx      = 0;
      err_cnt_o   = 0;
      check_cnt_o = 0;
    end else begin
      // Memory writes in arrival order
      if (mem_en_i && mem_we_i) begin
        if (exp_writes.size() == 0) begin
          $display("Unexpected memory write to address %h", mem_addr_i);
          err_cnt_o = err_cnt_o + 1;
        end else begin
          w           = exp_writes.pop_front();
          check_cnt_o = check_cnt_o + 1;
          if (mem_addr_i !== w.addr) begin
            $display("[FAIL] mem_addr_o expected %h got %h", w.addr, mem_addr_i);
            err_cnt_o = err_cnt_o + 1;
          end
          if (mem_wdata_i !== w.data) begin
            $display("[FAIL] mem_wdata_o expected %h got %h", w.data, mem_wdata_i);
            err_cnt_o = err_cnt_o + 1;
          end
        end
      end
      // One output flit per transfer
      if (out_valid_i && out_ready_i) begin
        if (exp_flits.size() == 0) begin
          $display("Output flit %h sent with no response outstanding", out_flit_i);
          err_cnt_o = err_cnt_o + 1;
        end else begin
          f           = exp_flits.pop_front();
          check_cnt_o = check_cnt_o + 1;
          if (out_flit_i !== f) begin
            $display("[FAIL] noc_out_flit_o expected %h got %h", f, out_flit_i);
            err_cnt_o = err_cnt_o + 1;
          end
        end
      end
      // An offered flit always finds room since one request never exceeds the buffer
      if (in_valid_i && !in_ready_i) begin
        $display("[FAIL] noc_in_ready_o expected %h got %h", 1'b1, in_ready_i);
        err_cnt_o = err_cnt_o + 1;
      end
      // Request parsing goes header first then addresses then data
      if (in_valid_i && in_ready_i) begin
        if (in_idx == 0) begin
          req_hdr = in_flit_i.content;
        end else if (in_idx == 1) begin
          laddr = in_flit_i.content;
        end else if (req_hdr.ptype == R2L_REQ) begin
          raddr = in_flit_i.content;
        end else begin
          a      = laddr + ADDR_WIDTH'(4 * (in_idx - 2));
          w.addr = a;
          w.data = in_flit_i.content;
          exp_writes.push_back(w);
          mem_copy[a[11:2]] = in_flit_i.content;
        end
        in_idx = in_idx + 1;
        if ((in_flit_i.ftype == LAST) || (in_flit_i.ftype == SINGLE)) begin
          if (req_hdr.ptype == R2L_REQ) begin
            queue_r2l_resp();
          end else begin
            queue_l2r_resp();
          end
          in_idx = 0;
        end
      end
    end
    pending_o = exp_writes.size() + exp_flits.size();
  end

endmodule

/* verification/dma_target_props.sv */
// DMA target protocol assertions on the NoC output and local memory ports
`timescale 1ns/1ps

module dma_target_props (
  input  logic                  clk,
  input  logic                  rst,
  input  dma_target_pkg::flit_t out_flit_i,
  input  logic                  out_valid_i,
  input  logic                  out_ready_i,
  input  logic                  mem_en_i,
  input  logic                  mem_we_i
);

  //////////////////////////////
  // NoC output handshake
  //////////////////////////////

  // A stalled flit stays offered and unchanged
  a_out_stable: assert property (@(posedge clk) disable iff (rst)
    (out_valid_i && !out_ready_i) |=> (out_valid_i && $stable(out_flit_i)))
    else $error("NoC output flit changed or was withdrawn while stalled");

  //////////////////////////////
  // Memory strobes
  //////////////////////////////

  // Memory stays idle while reset is held
  a_no_mem_in_reset: assert property (@(posedge clk) rst |-> !mem_en_i)
    else $error("Memory enabled during reset");

  // Write-enable only qualifies an enabled access
  a_we_needs_en: assert property (@(posedge clk) mem_we_i |-> mem_en_i)
    else $error("Memory write-enable high without enable");

endmodule

/* rtl/dma_target.sv */
// DMA target top: input packet buffer, request controller and read FIFO in a pipeline
`timescale 1ns/1ps

module dma_target #(
  parameter logic [dma_target_pkg::TILE_ID_WIDTH-1:0] tile_id = '0
) (
  input  logic                                  clk,
  input  logic                                  rst,

  // NoC input
  input  dma_target_pkg::flit_t                 noc_in_flit_i,
  input  logic                                  noc_in_valid_i,
  output logic                                  noc_in_ready_o,

  // NoC output
  output dma_target_pkg::flit_t                 noc_out_flit_o,
  output logic                                  noc_out_valid_o,
  input  logic                                  noc_out_ready_i,

  // Local memory
  output logic                                  mem_en_o,
  output logic                                  mem_we_o,
  output logic [dma_target_pkg::ADDR_WIDTH-1:0] mem_addr_o,
  output logic [dma_target_pkg::DATA_WIDTH-1:0] mem_wdata_o,
  input  logic [dma_target_pkg::DATA_WIDTH-1:0] mem_rdata_i
);
  import dma_target_pkg::*;

  // Buffer to controller
  flit_t                 buf_flit;
  logic                  buf_valid;
  logic                  buf_ready;

  // Controller and read FIFO
  logic                  rd_push;
  logic                  rd_pop;
  logic [DATA_WIDTH-1:0] fifo_data;
  logic                  fifo_valid;
  logic [1:0]            fifo_count;

  dma_packet_buffer u_buffer (
    .clk         (clk),
    .rst         (rst),
    .in_flit_i   (noc_in_flit_i),
    .in_valid_i  (noc_in_valid_i),
    .in_ready_o  (noc_in_ready_o),
    .out_flit_o  (buf_flit),
    .out_valid_o (buf_valid),
    .out_ready_i (buf_ready)
  );

  dma_request_ctrl #(
    .tile_id (tile_id)
  ) u_ctrl (
    .clk             (clk),
    .rst             (rst),
    .req_flit_i      (buf_flit),
    .req_valid_i     (buf_valid),
    .req_ready_o     (buf_ready),
    .mem_en_o        (mem_en_o),
    .mem_we_o        (mem_we_o),
    .mem_addr_o      (mem_addr_o),
    .mem_wdata_o     (mem_wdata_o),
    .rd_push_o       (rd_push),
    .fifo_data_i     (fifo_data),
    .fifo_valid_i    (fifo_valid),
    .fifo_count_i    (fifo_count),
    .rd_pop_o        (rd_pop),
    .noc_out_flit_o  (noc_out_flit_o),
    .noc_out_valid_o (noc_out_valid_o),
    .noc_out_ready_i (noc_out_ready_i)
  );

  // Memory read data goes straight into the FIFO
  dma_read_fifo u_read_fifo (
    .clk     (clk),
    .rst     (rst),
    .push_i  (rd_push),
    .data_i  (mem_rdata_i),
    .pop_i   (rd_pop),
    .data_o  (fifo_data),
    .valid_o (fifo_valid),
    .count_o (fifo_count)
  );

endmodule

/* dma_engine/dma_request_ctrl.sv */
// DMA request controller: decodes requests, drives local memory and composes response flits
`timescale 1ns/1ps

module dma_request_ctrl #(
  parameter logic [dma_target_pkg::TILE_ID_WIDTH-1:0] tile_id = '0
) (
  input  logic                                  clk,
  input  logic                                  rst,

  // Request flits from the packet buffer
  input  dma_target_pkg::flit_t                 req_flit_i,
  input  logic                                  req_valid_i,
  output logic                                  req_ready_o,

  // Local memory
  output logic                                  mem_en_o,
  output logic                                  mem_we_o,
  output logic [dma_target_pkg::ADDR_WIDTH-1:0] mem_addr_o,
  output logic [dma_target_pkg::DATA_WIDTH-1:0] mem_wdata_o,

  // Read FIFO
  output logic                                  rd_push_o,
  input  logic [dma_target_pkg::DATA_WIDTH-1:0] fifo_data_i,
  input  logic                                  fifo_valid_i,
  input  logic [1:0]                            fifo_count_i,
  output logic                                  rd_pop_o,

  // NoC output
  output dma_target_pkg::flit_t                 noc_out_flit_o,
  output logic                                  noc_out_valid_o,
  input  logic                                  noc_out_ready_i
);
  import dma_target_pkg::*;

  ctrl_state_e                state;
  ctrl_state_e                state_nxt;

  // Request fields latched from the incoming packet
  header_t                    hdr_in;
  logic [TILE_ID_WIDTH-1:0]   src_tile;
  logic [PACKET_ID_WIDTH-1:0] packet_id;
  logic [SIZE_WIDTH-1:0]      words_total;
  logic [ADDR_WIDTH-1:0]      laddr;
  logic [ADDR_WIDTH-1:0]      raddr;

  // L2R write index
  logic [SIZE_WIDTH-1:0]      wr_cnt;
  // Response bookkeeping: earlier packets, this packet, reads issued
  logic [SIZE_WIDTH-1:0]      words_sent;
  logic [PKT_CNT_WIDTH-1:0]   pkt_words;
  logic [PKT_CNT_WIDTH-1:0]   pkt_sent;
  logic [PKT_CNT_WIDTH-1:0]   rd_issued;

  logic [SIZE_WIDTH-1:0]      words_left;
  logic [SIZE_WIDTH-1:0]      pkt_size;
  logic [ADDR_WIDTH-1:0]      word_idx;
  header_t                    resp_hdr;
  logic                       req_fire;
  logic                       out_fire;
  logic                       rd_en;
  logic                       pkt_last;

  assign hdr_in   = req_flit_i.content;
  assign req_fire = req_valid_i & req_ready_o;
  assign out_fire = noc_out_valid_o & noc_out_ready_i;

  assign words_left = words_total - words_sent;
  // At most 14 payload words per response packet
  assign pkt_size   = (words_left < SIZE_WIDTH'(MAX_PAYLOAD_WORDS)) ?
                      words_left : SIZE_WIDTH'(MAX_PAYLOAD_WORDS);
  assign pkt_last   = (pkt_sent == pkt_words - 1'b1);

  // Read only while FIFO entries plus the read in flight leave room
  assign rd_en = ((state == R2L_GENADDR) | (state == R2L_DATA)) & (rd_issued < pkt_words) &
                 ((3'(fifo_count_i) + 3'(rd_push_o)) < 3'd3);

  // Word offset from the local base address
  assign word_idx    = (state == L2R_DATA) ? ADDR_WIDTH'(wr_cnt) :
                       ADDR_WIDTH'(words_sent) + ADDR_WIDTH'(rd_issued);
  assign mem_addr_o  = laddr + (word_idx << 2);
  assign mem_wdata_o = req_flit_i.content;

  //////////////////////////////
  // Next state and outputs
  //////////////////////////////

  always_comb begin
    state_nxt       = state;
    req_ready_o     = 1'b0;
    mem_en_o        = 1'b0;
    mem_we_o        = 1'b0;
    rd_pop_o        = 1'b0;
    noc_out_valid_o = 1'b0;
    noc_out_flit_o  = '0;

    // Fields common to both response kinds
    resp_hdr           = '0;
    resp_hdr.dest      = src_tile;
    resp_hdr.pclass    = PACKET_CLASS_DMA;
    resp_hdr.src       = tile_id;
    resp_hdr.packet_id = packet_id;

    case (state)
      IDLE: begin
        req_ready_o = 1'b1;
        if (req_valid_i) begin
          state_nxt = (hdr_in.ptype == R2L_REQ) ? R2L_GETLADDR : L2R_GETADDR;
        end
      end
      L2R_GETADDR: begin
        req_ready_o = 1'b1;
        if (req_valid_i) begin
          state_nxt = L2R_DATA;
        end
      end
      L2R_DATA: begin
        // Each accepted data flit is written in the same cycle
        req_ready_o = 1'b1;
        mem_en_o    = req_valid_i;
        mem_we_o    = req_valid_i;
        if (req_valid_i && (wr_cnt == words_total - 1'b1)) begin
          state_nxt = L2R_SENDRESP;
        end
      end
      L2R_SENDRESP: begin
        resp_hdr.ptype        = L2R_RESP;
        noc_out_valid_o       = 1'b1;
        noc_out_flit_o.ftype  = SINGLE;
        noc_out_flit_o.content = resp_hdr;
        if (noc_out_ready_i) begin
          state_nxt = IDLE;
        end
      end
      R2L_GETLADDR: begin
        req_ready_o = 1'b1;
        if (req_valid_i) begin
          state_nxt = R2L_GETRADDR;
        end
      end
      R2L_GETRADDR: begin
        req_ready_o = 1'b1;
        if (req_valid_i) begin
          state_nxt = R2L_GENHDR;
        end
      end
      R2L_GENHDR: begin
        resp_hdr.ptype         = R2L_RESP;
        resp_hdr.size          = pkt_size;
        resp_hdr.last          = (words_left <= SIZE_WIDTH'(MAX_PAYLOAD_WORDS));
        noc_out_valid_o        = 1'b1;
        noc_out_flit_o.ftype   = HEADER;
        noc_out_flit_o.content = resp_hdr;
        if (noc_out_ready_i) begin
          state_nxt = R2L_GENADDR;
        end
      end
      R2L_GENADDR: begin
        // Reads for this packet may already start here
        mem_en_o               = rd_en;
        noc_out_valid_o        = 1'b1;
        noc_out_flit_o.ftype   = PAYLOAD;
        noc_out_flit_o.content = raddr + (ADDR_WIDTH'(words_sent) << 2);
        if (noc_out_ready_i) begin
          state_nxt = R2L_DATA;
        end
      end
      R2L_DATA: begin
        mem_en_o               = rd_en;
        noc_out_valid_o        = fifo_valid_i;
        noc_out_flit_o.ftype   = pkt_last ? LAST : PAYLOAD;
        noc_out_flit_o.content = fifo_data_i;
        rd_pop_o               = out_fire;
        if (out_fire && pkt_last) begin
          // Done once this packet covers everything left
          state_nxt = (words_left == SIZE_WIDTH'(pkt_words)) ? IDLE : R2L_GENHDR;
        end
      end
      default: begin
        state_nxt = IDLE;
      end
    endcase
  end

  // Request fields, loaded as the matching flit is accepted
  always_ff @(posedge clk) begin
    if (req_fire) begin
      case (state)
        IDLE: begin
          src_tile    <= hdr_in.src;
          packet_id   <= hdr_in.packet_id;
          words_total <= hdr_in.size;
        end
        L2R_GETADDR, R2L_GETLADDR: laddr <= req_flit_i.content;
        R2L_GETRADDR:              raddr <= req_flit_i.content;
        default: ;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state      <= IDLE;
      rd_push_o  <= 1'b0;
      wr_cnt     <= '0;
      words_sent <= '0;
      pkt_words  <= '0;
      pkt_sent   <= '0;
      rd_issued  <= '0;
    end else begin
      state <= state_nxt;
      // Read data shows up one cycle after the strobe
      rd_push_o <= rd_en;
      if (rd_en) begin
        rd_issued <= rd_issued + 1'b1;
      end
      case (state)
        L2R_GETADDR:  wr_cnt <= '0;
        L2R_DATA: begin
          if (req_fire) begin
            wr_cnt <= wr_cnt + 1'b1;
          end
        end
        R2L_GETRADDR: words_sent <= '0;
        R2L_GENHDR: begin
          // Start a new response packet
          if (out_fire) begin
            pkt_words <= pkt_size[PKT_CNT_WIDTH-1:0];
            pkt_sent  <= '0;
            rd_issued <= '0;
          end
        end
        R2L_DATA: begin
          if (out_fire) begin
            pkt_sent <= pkt_sent + 1'b1;
            if (pkt_last) begin
              words_sent <= words_sent + SIZE_WIDTH'(pkt_words);
            end
          end
        end
        default: ;
      endcase
    end
  end

endmodule

/* dma_engine/dma_read_fifo.sv */
// Three-entry shift FIFO holding memory read data on its way to the NoC output
`timescale 1ns/1ps

module dma_read_fifo (
  input  logic                                  clk,
  input  logic                                  rst,
  input  logic                                  push_i,
  input  logic [dma_target_pkg::DATA_WIDTH-1:0] data_i,
  input  logic                                  pop_i,
  output logic [dma_target_pkg::DATA_WIDTH-1:0] data_o,
  output logic                                  valid_o,
  output logic [1:0]                            count_o
);
  import dma_target_pkg::*;

  // Entry 0 is the head
  logic [DATA_WIDTH-1:0] data_q [3];
  // Value each entry takes when the FIFO shifts, last entry keeps its own
  logic [DATA_WIDTH-1:0] upper [3];
  // One-hot write position, bit 0 means empty and bit 3 full
  logic [3:0]            pos;

  assign data_o  = data_q[0];
  assign valid_o = ~pos[0];
  // Count from the registered position only
  assign count_o = {pos[3] | pos[2], pos[3] | pos[1]};

  assign upper[0] = data_q[1];
  assign upper[1] = data_q[2];
  assign upper[2] = data_q[2];

  always_ff @(posedge clk) begin
    if (rst) begin
      pos <= 4'b0001;
    end else if (push_i & ~pop_i) begin
      pos <= pos << 1;
    end else if (~push_i & pop_i) begin
      pos <= pos >> 1;
    end
  end

  //////////////////////////////
  // Data shift
  //////////////////////////////

  always_ff @(posedge clk) begin
    for (int i = 0; i < 3; i++) begin
      if (pop_i) begin
        // On push and pop the new word lands one below the write position
        if (push_i & pos[i+1]) begin
          data_q[i] <= data_i;
        end else begin
          data_q[i] <= upper[i];
        end
      end else if (push_i & pos[i]) begin
        data_q[i] <= data_i;
      end
    end
  end

endmodule

/* rtl/dma_packet_buffer.sv */
// Input flit FIFO that hands a packet to the controller only once it is stored completely
`timescale 1ns/1ps

module dma_packet_buffer (
  input  logic                  clk,
  input  logic                  rst,

  // NoC side
  input  dma_target_pkg::flit_t in_flit_i,
  input  logic                  in_valid_i,
  output logic                  in_ready_o,

  // Controller side
  output dma_target_pkg::flit_t out_flit_o,
  output logic                  out_valid_o,
  input  logic                  out_ready_i
);
  import dma_target_pkg::*;

  // Flit storage
  flit_t                    mem [NOC_PACKET_SIZE];

  // Pointers wrap at the power-of-two depth
  logic [PKT_CNT_WIDTH-1:0] wr_ptr;
  logic [PKT_CNT_WIDTH-1:0] rd_ptr;
  // Flits stored and complete packets stored
  logic [PKT_CNT_WIDTH:0]   fill;
  logic [PKT_CNT_WIDTH:0]   pkt_cnt;

  logic                     push;
  logic                     pop;
  logic                     push_end;
  logic                     pop_end;

  // Back-pressure only when every slot is taken
  assign in_ready_o  = (fill != (PKT_CNT_WIDTH + 1)'(NOC_PACKET_SIZE));
  // Head flit belongs to a complete packet whenever one is counted
  assign out_valid_o = (pkt_cnt != '0);
  assign out_flit_o  = mem[rd_ptr];

  assign push = in_valid_i & in_ready_o;
  assign pop  = out_valid_o & out_ready_i;

  // Packet boundaries on either side
  assign push_end = push & ((in_flit_i.ftype == LAST) | (in_flit_i.ftype == SINGLE));
  assign pop_end  = pop & ((out_flit_o.ftype == LAST) | (out_flit_o.ftype == SINGLE));

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= in_flit_i;
    end
  end

  //////////////////////////////
  // Pointers and counters
  //////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr  <= '0;
      rd_ptr  <= '0;
      fill    <= '0;
      pkt_cnt <= '0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      // Simultaneous push and pop leaves the fill level alone
      if (push & ~pop) begin
        fill <= fill + 1'b1;
      end else if (~push & pop) begin
        fill <= fill - 1'b1;
      end
      // Packet becomes visible one cycle after its last flit arrives
      if (push_end & ~pop_end) begin
        pkt_cnt <= pkt_cnt + 1'b1;
      end else if (~push_end & pop_end) begin
        pkt_cnt <= pkt_cnt - 1'b1;
      end
    end
  end

endmodule

/* common/dma_target_pkg.sv */
// DMA target shared types: flit and header layout, state and opcode enums, NoC sizes
package dma_target_pkg;

  //////////////////////////////
  // NoC and packet dimensions
  //////////////////////////////

  // Flit is a 2-bit type on top of a 32-bit content word
  localparam int FLIT_WIDTH = 34;
  localparam int DATA_WIDTH = 32;
  // Byte addresses, words are 4 bytes apart
  localparam int ADDR_WIDTH = 32;

  // Header, address and up to 14 data flits
  localparam int NOC_PACKET_SIZE   = 16;
  localparam int MAX_PAYLOAD_WORDS = NOC_PACKET_SIZE - 2;
  // Index width for one packet worth of flits
  localparam int PKT_CNT_WIDTH     = $clog2(NOC_PACKET_SIZE);

  // Header field widths
  localparam int SIZE_WIDTH      = 12;
  localparam int TILE_ID_WIDTH   = 5;
  localparam int PACKET_ID_WIDTH = 4;

  // Class code that routes a packet to the DMA unit
  localparam logic [2:0] PACKET_CLASS_DMA = 3'b010;

  //////////////////////////////
  // Encodings
  //////////////////////////////

  // Flit position within a packet
  typedef enum logic [1:0] {
    PAYLOAD = 2'b00,
    HEADER  = 2'b01,
    LAST    = 2'b10,
    SINGLE  = 2'b11
  } flit_type_e;

  // Request and response opcodes
  typedef enum logic [1:0] {
    L2R_REQ  = 2'b00,
    R2L_REQ  = 2'b01,
    L2R_RESP = 2'b10,
    R2L_RESP = 2'b11
  } packet_type_e;

  typedef struct packed {
    flit_type_e            ftype;
    logic [DATA_WIDTH-1:0] content;
  } flit_t;

  // Content of a header flit, MSB first
  typedef struct packed {
    logic [TILE_ID_WIDTH-1:0]   dest;
    logic [2:0]                 pclass;
    logic [TILE_ID_WIDTH-1:0]   src;
    logic [PACKET_ID_WIDTH-1:0] packet_id;
    packet_type_e               ptype;
    // Word count of the request or of this response packet
    logic [SIZE_WIDTH-1:0]      size;
    // Set on the final packet of a response
    logic                       last;
  } header_t;

  // Request controller states
  typedef enum logic [3:0] {
    IDLE,
    L2R_GETADDR,
    L2R_DATA,
    L2R_SENDRESP,
    R2L_GETLADDR,
    R2L_GETRADDR,
    R2L_GENHDR,
    R2L_GENADDR,
    R2L_DATA
  } ctrl_state_e;

endpackage
